/* Makefile */
SIM   = verilator
FLAGS = --binary --assert -Mdir obj_dir
TOP   = tbMipsControl
FLIST = build.f

SRCS = $(filter %.sv,$(shell cat $(FLIST))) $(wildcard include/*.svh)
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -e '** PASS **'

clean:
	rm -rf obj_dir

/* build.f */
+incdir+include
src/ctrlPkg.sv
src/ctrlBusIf.sv
src/specialDecode.sv
src/immDecode.sv
src/flowDecode.sv
src/controlSelect.sv
src/mipsControl.sv
tb/tbMipsControl.sv

/* src/controlSelect.sv */
`default_nettype none

module controlSelect
(
    input  logic              clk,
    input  logic              rst,
    ctrlBusIf.sink            special,
    ctrlBusIf.sink            imm,
    ctrlBusIf.sink            flow,
    output ctrlPkg::ctrlWordT ctrl,
    output logic              pcSrc
);
    import ctrlPkg::*;

    localparam int wordBits = $bits(ctrlWordT);

    ctrlWordT merged;

    // Masked OR gives the NOP word when nothing matched
    assign merged = ctrlWordT'(({wordBits{special.hit}} & special.word)
                             | ({wordBits{imm.hit}} & imm.word)
                             | ({wordBits{flow.hit}} & flow.word));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl  <= nopWord;
            pcSrc <= 1'b0;
        end
        else
        begin
            ctrl  <= merged;
            pcSrc <= (merged.npcType == npcBranch);  // Only conditional branches
        end
    end

    // Opcode classes are disjoint across the three decoders
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({special.hit, imm.hit, flow.hit}))
        else $error("controlSelect: more than one decoder hit");

endmodule

`default_nettype wire

/* src/ctrlBusIf.sv */
`default_nettype none

// One decoder's result on its way to the merging stage
interface ctrlBusIf;
    import ctrlPkg::*;

    logic     hit;   // Opcode class matched
    ctrlWordT word;  // NOP word while hit is low

    modport source
    (
        output hit,
        output word
    );

    modport sink
    (
        input hit,
        input word
    );

endinterface

`default_nettype wire

/* src/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // rt field codes under the REGIMM opcode
    localparam logic [4:0] regimmBltz = 5'd0;
    localparam logic [4:0] regimmBgez = 5'd1;

    typedef enum logic [5:0] {
        opSpecial = 6'd0,  // R-type, decoded by funct
        opRegimm  = 6'd1,  // bltz/bgez, decoded by rt
        opJ       = 6'd2,
        opJal     = 6'd3,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opBlez    = 6'd6,
        opBgtz    = 6'd7,
        opAddi    = 6'd8,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLb      = 6'd32,
        opLh      = 6'd33,
        opLw      = 6'd35,
        opLbu     = 6'd36,
        opLhu     = 6'd37,
        opSb      = 6'd40,
        opSh      = 6'd41,
        opSw      = 6'd43
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnJalr = 6'd9,
        fnAdd  = 6'd32,
        fnAddu = 6'd33,
        fnSub  = 6'd34,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnNor  = 6'd39,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functT;

    typedef enum logic [4:0] {
        aluNop, aluAdd, aluSub, aluSll, aluSrl, aluSra,
        aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu,
        aluAndi, aluOri, aluXori, aluLui,
        aluBne, aluBlez, aluBgtz, aluBltz, aluBgez  // Branch compares in EX
    } aluOpT;

    typedef enum logic [1:0] {npcSeq = 2'd0, npcBranch = 2'd1, npcJump = 2'd2} npcTypeT;

    typedef enum logic [1:0] {dstRt = 2'd0, dstRd = 2'd1, dstRa = 2'd2} regDstT;

    // Writeback mux: ALU result, load data or PC+4
    typedef enum logic [1:0] {wbAlu = 2'd0, wbMem = 2'd1, wbLink = 2'd2} memToRegT;

    typedef enum logic [1:0] {srcAReg = 2'd0, srcAShamt = 2'd1} srcAT;

    typedef enum logic [1:0] {srcBReg = 2'd0, srcBImm = 2'd1} srcBT;

    typedef enum logic [2:0] {
        memRNone  = 3'd0,
        memRWord  = 3'd1,
        memRByte  = 3'd2,
        memRByteU = 3'd3,  // Zero-extended
        memRHalf  = 3'd4,
        memRHalfU = 3'd5   // Zero-extended
    } memRWidthT;

    typedef enum logic [1:0] {
        memWNone = 2'd0,
        memWWord = 2'd1,
        memWHalf = 2'd2,
        memWByte = 2'd3
    } memWWidthT;

    typedef struct packed {
        logic      regWrite;
        regDstT    regDst;
        memToRegT  memToReg;
        logic      memRead;
        memRWidthT memRBits;
        logic      memWrite;
        memWWidthT memWrBits;
        aluOpT     aluOp;
        srcAT      aluSrcA;
        srcBT      aluSrcB;
        npcTypeT   npcType;
        logic      jumpSrc;  // 1 selects GPR[rs] as jump target
    } ctrlWordT;

    localparam ctrlWordT nopWord = '0;

endpackage

`default_nettype wire

/* src/flowDecode.sv */
`default_nettype none

module flowDecode
(
    input  ctrlPkg::opcodeT op,
    input  logic [4:0]      rt,
    ctrlBusIf.source        bus
);
    import ctrlPkg::*;

    logic     hit;
    ctrlWordT word;

    always_comb
    begin
        hit  = 1'b1;
        word = nopWord;
        case (op)
            opBeq, opBne, opBlez, opBgtz:
            begin
                word.npcType = npcBranch;  // Resolved by the branch unit in EX
                case (op)
                    opBeq:   word.aluOp = aluSub;
                    opBne:   word.aluOp = aluBne;
                    opBlez:  word.aluOp = aluBlez;
                    default: word.aluOp = aluBgtz;
                endcase
            end
            opRegimm:
            begin
                if (rt == regimmBltz)
                begin
                    word.npcType = npcBranch;
                    word.aluOp   = aluBltz;
                end
                else if (rt == regimmBgez)
                begin
                    word.npcType = npcBranch;
                    word.aluOp   = aluBgez;
                end
                else
                begin
                    hit = 1'b0;  // Other rt codes are not supported
                end
            end
            opJ:
            begin
                word.npcType = npcJump;  // Target from instr_index
            end
            opJal:
            begin
                word.npcType  = npcJump;
                word.regWrite = 1'b1;
                word.regDst   = dstRa;  // $31 <- PC+4
                word.memToReg = wbLink;
            end
            default: hit = 1'b0;
        endcase
    end

    assign bus.hit  = hit;
    assign bus.word = word;

endmodule

`default_nettype wire

/* src/immDecode.sv */
`default_nettype none

module immDecode
(
    input  ctrlPkg::opcodeT op,
    ctrlBusIf.source        bus
);
    import ctrlPkg::*;

    logic     hit;
    ctrlWordT word;

    always_comb
    begin
        hit          = 1'b1;
        word         = nopWord;
        word.aluSrcB = srcBImm;  // Extended imm16
        case (op)
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
            begin
                word.regWrite = 1'b1;
                word.regDst   = dstRt;
                case (op)
                    opAddi, opAddiu: word.aluOp = aluAdd;
                    opSlti:          word.aluOp = aluSlt;
                    opSltiu:         word.aluOp = aluSltu;
                    opAndi:          word.aluOp = aluAndi;
                    opOri:           word.aluOp = aluOri;
                    opXori:          word.aluOp = aluXori;
                    default:         word.aluOp = aluLui;
                endcase
            end
            opLb, opLh, opLw, opLbu, opLhu:
            begin
                word.regWrite = 1'b1;
                word.regDst   = dstRt;
                word.memToReg = wbMem;
                word.memRead  = 1'b1;
                word.aluOp    = aluAdd;  // Base plus offset
                case (op)
                    opLw:    word.memRBits = memRWord;
                    opLb:    word.memRBits = memRByte;
                    opLbu:   word.memRBits = memRByteU;
                    opLh:    word.memRBits = memRHalf;
                    default: word.memRBits = memRHalfU;
                endcase
            end
            opSb, opSh, opSw:
            begin
                word.memWrite = 1'b1;
                word.aluOp    = aluAdd;
                case (op)
                    opSw:    word.memWrBits = memWWord;
                    opSh:    word.memWrBits = memWHalf;
                    default: word.memWrBits = memWByte;
                endcase
            end
            default:
            begin
                hit  = 1'b0;
                word = nopWord;
            end
        endcase
    end

    assign bus.hit  = hit;
    assign bus.word = word;

    always_comb
    begin
        assert (!(bus.word.memRead && bus.word.memWrite))
            else $error("immDecode: memRead and memWrite both set");
    end

endmodule

`default_nettype wire

/* src/mipsControl.sv */
`default_nettype none

module mipsControl
(
    input  logic               clk,
    input  logic               rst,
    input  logic [5:0]         op,
    input  logic [5:0]         funct,
    input  logic [4:0]         rt,
    output logic               pcSrc,
    output ctrlPkg::npcTypeT   npcType,
    output ctrlPkg::regDstT    regDst,
    output logic               memRead,
    output ctrlPkg::memToRegT  memToReg,
    output ctrlPkg::aluOpT     aluOp,
    output logic               memWrite,
    output ctrlPkg::srcAT      aluSrcA,
    output ctrlPkg::srcBT      aluSrcB,
    output logic               regWrite,
    output ctrlPkg::memWWidthT memWrBits,
    output ctrlPkg::memRWidthT memRBits,
    output logic               jumpSrc
);
    import ctrlPkg::*;

    opcodeT   opField;
    functT    functField;
    ctrlWordT ctrl;

    assign opField    = opcodeT'(op);
    assign functField = functT'(funct);

    ctrlBusIf specialBus ();
    ctrlBusIf immBus ();
    ctrlBusIf flowBus ();

    specialDecode specialDec (.op(opField), .funct(functField), .bus(specialBus.source));
    immDecode     immDec (.op(opField), .bus(immBus.source));
    flowDecode    flowDec (.op(opField), .rt(rt), .bus(flowBus.source));

    controlSelect sel0
    (
        .clk(clk),
        .rst(rst),
        .special(specialBus.sink),
        .imm(immBus.sink),
        .flow(flowBus.sink),
        .ctrl(ctrl),
        .pcSrc(pcSrc)
    );

    assign regWrite  = ctrl.regWrite;
    assign regDst    = ctrl.regDst;
    assign memToReg  = ctrl.memToReg;
    assign memRead   = ctrl.memRead;
    assign memRBits  = ctrl.memRBits;
    assign memWrite  = ctrl.memWrite;
    assign memWrBits = ctrl.memWrBits;
    assign aluOp     = ctrl.aluOp;
    assign aluSrcA   = ctrl.aluSrcA;
    assign aluSrcB   = ctrl.aluSrcB;
    assign npcType   = ctrl.npcType;
    assign jumpSrc   = ctrl.jumpSrc;

endmodule

`default_nettype wire

/* src/specialDecode.sv */
`default_nettype none

module specialDecode
(
    input  ctrlPkg::opcodeT op,
    input  ctrlPkg::functT  funct,
    ctrlBusIf.source        bus
);
    import ctrlPkg::*;

    logic     hit;
    ctrlWordT word;

    always_comb
    begin
        hit  = 1'b0;
        word = nopWord;
        if (op == opSpecial)
        begin
            hit           = 1'b1;
            word.regWrite = 1'b1;  // rd <- ALU result
            word.regDst   = dstRd;
            case (funct)
                fnAdd, fnAddu: word.aluOp = aluAdd;
                fnSub, fnSubu: word.aluOp = aluSub;
                fnSll, fnSllv: word.aluOp = aluSll;
                fnSrl, fnSrlv: word.aluOp = aluSrl;
                fnSra, fnSrav: word.aluOp = aluSra;
                fnAnd:         word.aluOp = aluAnd;
                fnOr:          word.aluOp = aluOr;
                fnXor:         word.aluOp = aluXor;
                fnNor:         word.aluOp = aluNor;
                fnSlt:         word.aluOp = aluSlt;
                fnSltu:        word.aluOp = aluSltu;
                fnJalr:
                begin
                    word.memToReg = wbLink;  // rd <- PC+4
                    word.npcType  = npcJump;
                    word.jumpSrc  = 1'b1;
                end
                fnJr:
                begin
                    word.regWrite = 1'b0;
                    word.regDst   = dstRt;
                    word.npcType  = npcJump;
                    word.jumpSrc  = 1'b1;
                end
                default:
                begin
                    hit  = 1'b0;  // Unlisted funct falls back to NOP
                    word = nopWord;
                end
            endcase
            // Constant shifts take the amount from the shamt field
            if (funct inside {fnSll, fnSrl, fnSra})
            begin
                word.aluSrcA = srcAShamt;
            end
        end
    end

    assign bus.hit  = hit;
    assign bus.word = word;

    // A register jump must also steer the next-PC mux to jump
    always_comb
    begin
        assert (!bus.word.jumpSrc || bus.word.npcType == npcJump)
            else $error("specialDecode: jumpSrc set without npcType JUMP");
    end

endmodule

`default_nettype wire

/* include/ctrlVectors.svh */
typedef struct packed {
    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] rt;
    logic [1:0] rnd;        // Bit 0 randomizes funct, bit 1 randomizes rt
    logic       regWrite;
    logic [1:0] regDst, memToReg;
    logic       memRead;
    logic [2:0] memRBits;
    logic       memWrite;
    logic [1:0] memWrBits;
    logic [4:0] aluOp;
    logic [1:0] aluSrcA, aluSrcB, npcType;
    logic       jumpSrc, pcSrc;
} vecRowT;

localparam int numRows = 46;

// One row per instruction, fields in vecRowT order
localparam vecRowT vecTable [numRows] = '{
    '{ 0,  0, 0, 2, 1, 1, 0, 0, 0, 0, 0,  3, 1, 0, 0, 0, 0},  // sll
    '{ 0,  2, 0, 2, 1, 1, 0, 0, 0, 0, 0,  4, 1, 0, 0, 0, 0},  // srl
    '{ 0,  3, 0, 2, 1, 1, 0, 0, 0, 0, 0,  5, 1, 0, 0, 0, 0},  // sra
    '{ 0,  4, 0, 2, 1, 1, 0, 0, 0, 0, 0,  3, 0, 0, 0, 0, 0},  // sllv
    '{ 0,  6, 0, 2, 1, 1, 0, 0, 0, 0, 0,  4, 0, 0, 0, 0, 0},  // srlv
    '{ 0,  7, 0, 2, 1, 1, 0, 0, 0, 0, 0,  5, 0, 0, 0, 0, 0},  // srav
    '{ 0,  8, 0, 2, 0, 0, 0, 0, 0, 0, 0,  0, 0, 0, 2, 1, 0},  // jr
    '{ 0,  9, 0, 2, 1, 1, 2, 0, 0, 0, 0,  0, 0, 0, 2, 1, 0},  // jalr
    '{ 0, 32, 0, 2, 1, 1, 0, 0, 0, 0, 0,  1, 0, 0, 0, 0, 0},  // add
    '{ 0, 33, 0, 2, 1, 1, 0, 0, 0, 0, 0,  1, 0, 0, 0, 0, 0},  // addu
    '{ 0, 34, 0, 2, 1, 1, 0, 0, 0, 0, 0,  2, 0, 0, 0, 0, 0},  // sub
    '{ 0, 35, 0, 2, 1, 1, 0, 0, 0, 0, 0,  2, 0, 0, 0, 0, 0},  // subu
    '{ 0, 36, 0, 2, 1, 1, 0, 0, 0, 0, 0,  6, 0, 0, 0, 0, 0},  // and
    '{ 0, 37, 0, 2, 1, 1, 0, 0, 0, 0, 0,  7, 0, 0, 0, 0, 0},  // or
    '{ 0, 38, 0, 2, 1, 1, 0, 0, 0, 0, 0,  8, 0, 0, 0, 0, 0},  // xor
    '{ 0, 39, 0, 2, 1, 1, 0, 0, 0, 0, 0,  9, 0, 0, 0, 0, 0},  // nor
    '{ 0, 42, 0, 2, 1, 1, 0, 0, 0, 0, 0, 10, 0, 0, 0, 0, 0},  // slt
    '{ 0, 43, 0, 2, 1, 1, 0, 0, 0, 0, 0, 11, 0, 0, 0, 0, 0},  // sltu
    '{ 0,  1, 0, 2, 0, 0, 0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0},  // Unlisted funct
    '{ 8,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0,  1, 0, 1, 0, 0, 0},  // addi
    '{ 9,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0,  1, 0, 1, 0, 0, 0},  // addiu
    '{10,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0, 10, 0, 1, 0, 0, 0},  // slti
    '{11,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0, 11, 0, 1, 0, 0, 0},  // sltiu
    '{12,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0, 12, 0, 1, 0, 0, 0},  // andi
    '{13,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0, 13, 0, 1, 0, 0, 0},  // ori
    '{14,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0, 14, 0, 1, 0, 0, 0},  // xori
    '{15,  0, 0, 3, 1, 0, 0, 0, 0, 0, 0, 15, 0, 1, 0, 0, 0},  // lui
    '{32,  0, 0, 3, 1, 0, 1, 1, 2, 0, 0,  1, 0, 1, 0, 0, 0},  // lb
    '{33,  0, 0, 3, 1, 0, 1, 1, 4, 0, 0,  1, 0, 1, 0, 0, 0},  // lh
    '{35,  0, 0, 3, 1, 0, 1, 1, 1, 0, 0,  1, 0, 1, 0, 0, 0},  // lw
    '{36,  0, 0, 3, 1, 0, 1, 1, 3, 0, 0,  1, 0, 1, 0, 0, 0},  // lbu
    '{37,  0, 0, 3, 1, 0, 1, 1, 5, 0, 0,  1, 0, 1, 0, 0, 0},  // lhu
    '{40,  0, 0, 3, 0, 0, 0, 0, 0, 1, 3,  1, 0, 1, 0, 0, 0},  // sb
    '{41,  0, 0, 3, 0, 0, 0, 0, 0, 1, 2,  1, 0, 1, 0, 0, 0},  // sh
    '{43,  0, 0, 3, 0, 0, 0, 0, 0, 1, 1,  1, 0, 1, 0, 0, 0},  // sw
    '{ 4,  0, 0, 3, 0, 0, 0, 0, 0, 0, 0,  2, 0, 0, 1, 0, 1},  // beq
    '{ 5,  0, 0, 3, 0, 0, 0, 0, 0, 0, 0, 16, 0, 0, 1, 0, 1},  // bne
    '{ 6,  0, 0, 3, 0, 0, 0, 0, 0, 0, 0, 17, 0, 0, 1, 0, 1},  // blez
    '{ 7,  0, 0, 3, 0, 0, 0, 0, 0, 0, 0, 18, 0, 0, 1, 0, 1},  // bgtz
    '{ 1,  0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 19, 0, 0, 1, 0, 1},  // bltz
    '{ 1,  0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 20, 0, 0, 1, 0, 1},  // bgez
    '{ 1,  0, 2, 3, 0, 0, 0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0},  // REGIMM, other rt
    '{ 2,  0, 0, 3, 0, 0, 0, 0, 0, 0, 0,  0, 0, 0, 2, 0, 0},  // j
    '{ 3,  0, 0, 3, 1, 2, 2, 0, 0, 0, 0,  0, 0, 0, 2, 0, 0},  // jal
    '{16,  0, 0, 3, 0, 0, 0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0},  // Unlisted opcode
    '{63,  0, 0, 3, 0, 0, 0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0}   // Unlisted opcode
};

/* tb/tbMipsControl.sv */
`default_nettype none

module tbMipsControl;
    import ctrlPkg::*;

    `include "ctrlVectors.svh"

    logic       clk = 1'b0;
    logic       rst;
    logic [5:0] op, funct;
    logic [4:0] rt;
    logic       pcSrc, memRead, memWrite, regWrite, jumpSrc;
    npcTypeT    npcType;
    regDstT     regDst;
    memToRegT   memToReg;
    aluOpT      aluOp;
    srcAT       aluSrcA;
    srcBT       aluSrcB;
    memWWidthT  memWrBits;
    memRWidthT  memRBits;

    logic [31:0] lfsrState;
    int          checkErrors = 0;
    int          lastErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    mipsControl dut0 (.*);

    always #50 clk = ~clk;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int count);
        logic        fb;
        logic [31:0] value;
        value = '0;
        for (int n = 0; n < count; n++)
        begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value     = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want)
        begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
            checkErrors++;
        end
    endtask

    task automatic checkOutputs(input vecRowT want);
        checkValue("pcSrc", 32'(pcSrc), 32'(want.pcSrc));
        checkValue("npcType", 32'(npcType), 32'(want.npcType));
        checkValue("regDst", 32'(regDst), 32'(want.regDst));
        checkValue("memRead", 32'(memRead), 32'(want.memRead));
        checkValue("memToReg", 32'(memToReg), 32'(want.memToReg));
        checkValue("aluOp", 32'(aluOp), 32'(want.aluOp));
        checkValue("memWrite", 32'(memWrite), 32'(want.memWrite));
        checkValue("aluSrcA", 32'(aluSrcA), 32'(want.aluSrcA));
        checkValue("aluSrcB", 32'(aluSrcB), 32'(want.aluSrcB));
        checkValue("regWrite", 32'(regWrite), 32'(want.regWrite));
        checkValue("memWrBits", 32'(memWrBits), 32'(want.memWrBits));
        checkValue("memRBits", 32'(memRBits), 32'(want.memRBits));
        checkValue("jumpSrc", 32'(jumpSrc), 32'(want.jumpSrc));
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (checkErrors != lastErrors)
            testsFailed++;
        $display("%s: %s", name, (checkErrors != lastErrors) ? "failed" : "ok");
        lastErrors = checkErrors;
    endtask

    // Drive one row with ignored fields taken from the LFSR
    task automatic applyRow(input vecRowT row);
        logic [31:0] bits;
        op    <= row.op;
        funct <= row.funct;
        rt    <= row.rt;
        if (row.rnd[0])
        begin
            bits = randomBits(6);
            funct <= bits[5:0];
        end
        if (row.rnd[1])
        begin
            bits = randomBits(5);
            // REGIMM rows draw an rt other than bltz and bgez
            rt <= (row.op == opRegimm && bits[4:0] < 5'd2) ? bits[4:0] + 5'd2 : bits[4:0];
        end
    endtask

    initial
    begin
        int i;
        rst       = 1'b1;
        op        = opLw;  // Non-NOP word that only reset can hide
        funct     = '0;
        rt        = '0;
        lfsrState = 32'h881a2974;

        @(negedge clk);
        checkOutputs('0);  // Inside the reset window
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkOutputs('0);  // After the last edge with rst high
        reportTest("reset");

        // Each row must show up exactly one edge after it is driven
        @(posedge clk);
        applyRow(vecTable[0]);
        for (i = 1; i <= numRows; i++)
        begin
            @(posedge clk);
            if (i < numRows)
                applyRow(vecTable[i]);
            @(negedge clk);
            checkOutputs(vecTable[i - 1]);
            reportTest($sformatf("row %0d op 0x%0h funct 0x%0h rt 0x%0h", i - 1,
                                 vecTable[i - 1].op, vecTable[i - 1].funct,
                                 vecTable[i - 1].rt));
        end

        $display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed,
                 checkErrors);
        if (testsFailed == 0 && checkErrors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
